/* rtl/obi_pkg.sv */
//****************************************
// obi package
// widths and master count of the reduced OBI
//****************************************

`default_nettype none

package obi_pkg;

  // address and data paths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH = DATA_WIDTH / 8;

  // external masters on the bus
  localparam int unsigned NUM_MASTERS = 2;
  localparam int unsigned MASTER_IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

endpackage : obi_pkg

`default_nettype wire

/* rtl/core_v_mini_mcu_pkg.sv */
//****************************************
// mcu package
// memory map, ram banking and register offsets
//****************************************

`default_nettype none

package core_v_mini_mcu_pkg;

  // on-chip ram
  localparam int unsigned MEM_SIZE = 4096;
  localparam int unsigned NUM_BANKS = 2;
  localparam int unsigned BANK_IDX_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
  // bank select sits just above one bank's byte range, bit 11
  localparam int unsigned RAM_BANK_BIT = $clog2(MEM_SIZE / NUM_BANKS);

  localparam logic [31:0] RAM_START_ADDRESS = 32'h0000_0000;
  localparam logic [31:0] AO_PERIPH_START_ADDRESS = 32'h2000_0000;
  localparam logic [31:0] AO_PERIPH_SIZE = 32'h0000_1000;
  localparam logic [31:0] PERIPH_START_ADDRESS = 32'h3000_0000;
  localparam logic [31:0] PERIPH_SIZE = 32'h0000_1000;

  // register offsets inside a 4 KiB window
  localparam int unsigned REG_OFFSET_W = 12;

  localparam logic [REG_OFFSET_W-1:0] EXIT_VALID_OFFSET = 12'h000;
  localparam logic [REG_OFFSET_W-1:0] EXIT_VALUE_OFFSET = 12'h004;
  localparam logic [REG_OFFSET_W-1:0] BOOT_SELECT_OFFSET = 12'h008;
  localparam logic [REG_OFFSET_W-1:0] MTIME_OFFSET = 12'h010;
  localparam logic [REG_OFFSET_W-1:0] MTIMECMP_OFFSET = 12'h014;
  localparam logic [REG_OFFSET_W-1:0] TIMER_CTRL_OFFSET = 12'h018;

  localparam logic [REG_OFFSET_W-1:0] GPIO_OUT_OFFSET = 12'h000;
  localparam logic [REG_OFFSET_W-1:0] GPIO_EN_OFFSET = 12'h004;
  localparam logic [REG_OFFSET_W-1:0] GPIO_IN_OFFSET = 12'h008;

  localparam int unsigned GPIO_WIDTH = 32;

endpackage : core_v_mini_mcu_pkg

`default_nettype wire

/* rtl/system_bus.sv */
//****************************************
// system bus
// fixed-priority arbiter, decoder and response router
//****************************************

`default_nettype none

module system_bus
  import obi_pkg::*;
  import core_v_mini_mcu_pkg::*;
(
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,

  input  logic [NUM_MASTERS-1:0]                 req_i,
  input  logic [NUM_MASTERS-1:0]                 we_i,
  input  logic [NUM_MASTERS-1:0][BE_WIDTH-1:0]   be_i,
  input  logic [NUM_MASTERS-1:0][ADDR_WIDTH-1:0] addr_i,
  input  logic [NUM_MASTERS-1:0][DATA_WIDTH-1:0] wdata_i,
  output logic [NUM_MASTERS-1:0]                 gnt_o,
  output logic [NUM_MASTERS-1:0]                 rvalid_o,
  output logic [NUM_MASTERS-1:0][DATA_WIDTH-1:0] rdata_o,

  output logic [NUM_BANKS-1:0]                   ram_req_o,
  output logic                                   ram_we_o,
  output logic [BE_WIDTH-1:0]                    ram_be_o,
  output logic [ADDR_WIDTH-1:0]                  ram_addr_o,
  output logic [DATA_WIDTH-1:0]                  ram_wdata_o,
  input  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]   ram_rdata_i,

  output logic                                   ao_req_o,
  output logic                                   ao_we_o,
  output logic [ADDR_WIDTH-1:0]                  ao_addr_o,
  output logic [DATA_WIDTH-1:0]                  ao_wdata_o,
  input  logic [DATA_WIDTH-1:0]                  ao_rdata_i,

  output logic                                   periph_req_o,
  output logic                                   periph_we_o,
  output logic [ADDR_WIDTH-1:0]                  periph_addr_o,
  output logic [DATA_WIDTH-1:0]                  periph_wdata_o,
  input  logic [DATA_WIDTH-1:0]                  periph_rdata_i
);

  typedef enum logic [1:0] {TGT_NONE, TGT_RAM, TGT_AO, TGT_PERIPH} target_e;

  logic                    any_req;
  logic [MASTER_IDX_W-1:0] sel;
  logic                    we;
  logic [ADDR_WIDTH-1:0]   addr;
  target_e                 target;
  logic [BANK_IDX_W-1:0]   bank;

  // record of the transfer granted last cycle
  logic                    rvalid_q;
  logic                    we_q;
  logic [MASTER_IDX_W-1:0] master_q;
  target_e                 target_q;
  logic [BANK_IDX_W-1:0]   bank_q;
  logic [DATA_WIDTH-1:0]   resp_data;

  // lowest index wins, so scan from the top down
  always_comb begin
    sel = '0;
    any_req = 1'b0;
    for (int m = NUM_MASTERS - 1; m >= 0; m--) begin
      if (req_i[m]) begin
        sel = MASTER_IDX_W'(m);
        any_req = 1'b1;
      end
    end
  end

  always_comb begin
    gnt_o = '0;
    gnt_o[sel] = any_req;
  end

  assign we   = we_i[sel];
  assign addr = addr_i[sel];
  assign bank = addr[RAM_BANK_BIT +: BANK_IDX_W];

  always_comb begin
    if ((addr - RAM_START_ADDRESS) < ADDR_WIDTH'(MEM_SIZE)) begin
      target = TGT_RAM;
    end else if ((addr - AO_PERIPH_START_ADDRESS) < AO_PERIPH_SIZE) begin
      target = TGT_AO;
    end else if ((addr - PERIPH_START_ADDRESS) < PERIPH_SIZE) begin
      target = TGT_PERIPH;
    end else begin
      target = TGT_NONE;
    end
  end

  always_comb begin
    ram_req_o = '0;
    ram_req_o[bank] = any_req && (target == TGT_RAM);
  end

  assign ram_we_o       = we;
  assign ram_be_o       = be_i[sel];
  assign ram_addr_o     = addr;
  assign ram_wdata_o    = wdata_i[sel];

  assign ao_req_o       = any_req && (target == TGT_AO);
  assign ao_we_o        = we;
  assign ao_addr_o      = addr;
  assign ao_wdata_o     = wdata_i[sel];

  assign periph_req_o   = any_req && (target == TGT_PERIPH);
  assign periph_we_o    = we;
  assign periph_addr_o  = addr;
  assign periph_wdata_o = wdata_i[sel];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      we_q     <= 1'b0;
      master_q <= '0;
      target_q <= TGT_NONE;
      bank_q   <= '0;
    end else begin
      rvalid_q <= any_req;
      if (any_req) begin
        we_q     <= we;
        master_q <= sel;
        target_q <= target;
        bank_q   <= bank;
      end
    end
  end

  // writes and unmapped reads answer with zero
  always_comb begin
    case (target_q)
      TGT_RAM:    resp_data = ram_rdata_i[bank_q];
      TGT_AO:     resp_data = ao_rdata_i;
      TGT_PERIPH: resp_data = periph_rdata_i;
      default:    resp_data = '0;
    endcase
    if (we_q) begin
      resp_data = '0;
    end
  end

  always_comb begin
    for (int m = 0; m < NUM_MASTERS; m++) begin
      rvalid_o[m] = rvalid_q && (master_q == MASTER_IDX_W'(m));
      rdata_o[m]  = rvalid_o[m] ? resp_data : '0;
    end
  end

  a_gnt_onehot0 : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_o));

endmodule : system_bus

`default_nettype wire

/* rtl/memory_subsystem.sv */
//****************************************
// memory subsystem
// banked ram with byte-enable writes
//****************************************

`default_nettype none

module memory_subsystem
  import obi_pkg::*;
  import core_v_mini_mcu_pkg::*;
#(
  parameter int unsigned NUM_BYTES = MEM_SIZE
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic [NUM_BANKS-1:0]                 ram_req_i,
  input  logic                                 ram_we_i,
  input  logic [BE_WIDTH-1:0]                  ram_be_i,
  input  logic [ADDR_WIDTH-1:0]                ram_addr_i,
  input  logic [DATA_WIDTH-1:0]                ram_wdata_i,
  output logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] ram_rdata_o
);

  localparam int unsigned BANK_WORDS = NUM_BYTES / (NUM_BANKS * BE_WIDTH);
  localparam int unsigned WORD_AW = $clog2(BANK_WORDS);
  localparam int unsigned BYTE_AW = $clog2(BE_WIDTH);

  logic [WORD_AW-1:0] word_idx;

  // word index within a bank, below the bank select bit
  assign word_idx = ram_addr_i[BYTE_AW +: WORD_AW];

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    logic [DATA_WIDTH-1:0] mem [BANK_WORDS];
    logic [DATA_WIDTH-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
      if (ram_req_i[b]) begin
        if (ram_we_i) begin
          for (int i = 0; i < BE_WIDTH; i++) begin
            if (ram_be_i[i]) begin
              mem[word_idx][i*8 +: 8] <= ram_wdata_i[i*8 +: 8];
            end
          end
        end else begin
          rdata_q <= mem[word_idx];
        end
      end
    end

    assign ram_rdata_o[b] = rdata_q;
  end

  // the bus decoder must never select two banks at once
  a_one_bank : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(ram_req_i));

endmodule : memory_subsystem

`default_nettype wire

/* rtl/ao_peripheral_subsystem.sv */
//****************************************
// always-on peripherals
// exit and boot-select registers, machine timer
//****************************************

`default_nettype none

module ao_peripheral_subsystem
  import obi_pkg::*;
  import core_v_mini_mcu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  input  logic                  boot_select_i,
  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic                  exit_valid_o,
  output logic [DATA_WIDTH-1:0] exit_value_o,
  output logic                  irq_timer_o
);

  logic                    wr_en;
  logic                    rd_en;
  logic [REG_OFFSET_W-1:0] offset;

  logic [DATA_WIDTH-1:0]   mtime_q;
  logic [DATA_WIDTH-1:0]   mtimecmp_q;
  logic                    timer_en_q;

  assign wr_en  = req_i && we_i;
  assign rd_en  = req_i && !we_i;
  assign offset = addr_i[REG_OFFSET_W-1:0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
      mtime_q      <= '0;
      mtimecmp_q   <= '0;
      timer_en_q   <= 1'b0;
      irq_timer_o  <= 1'b0;
    end else begin
      // sticky until reset
      if (wr_en && (offset == EXIT_VALID_OFFSET) && wdata_i[0]) begin
        exit_valid_o <= 1'b1;
      end
      if (wr_en && (offset == EXIT_VALUE_OFFSET)) begin
        exit_value_o <= wdata_i;
      end
      // a software write takes precedence over the count
      if (wr_en && (offset == MTIME_OFFSET)) begin
        mtime_q <= wdata_i;
      end else if (timer_en_q) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_en && (offset == MTIMECMP_OFFSET)) begin
        mtimecmp_q <= wdata_i;
      end
      if (wr_en && (offset == TIMER_CTRL_OFFSET)) begin
        timer_en_q <= wdata_i[0];
      end
      irq_timer_o <= timer_en_q && (mtime_q >= mtimecmp_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      case (offset)
        EXIT_VALID_OFFSET:  rdata_o <= DATA_WIDTH'(exit_valid_o);
        EXIT_VALUE_OFFSET:  rdata_o <= exit_value_o;
        BOOT_SELECT_OFFSET: rdata_o <= DATA_WIDTH'(boot_select_i);
        MTIME_OFFSET:       rdata_o <= mtime_q;
        MTIMECMP_OFFSET:    rdata_o <= mtimecmp_q;
        TIMER_CTRL_OFFSET:  rdata_o <= DATA_WIDTH'(timer_en_q);
        default:            rdata_o <= '0;
      endcase
    end
  end

  a_exit_sticky : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$fell(exit_valid_o));

endmodule : ao_peripheral_subsystem

`default_nettype wire

/* rtl/peripheral_subsystem.sv */
//****************************************
// peripheral subsystem
// gpio out, enable and synchronized input
//****************************************

`default_nettype none

module peripheral_subsystem
  import obi_pkg::*;
  import core_v_mini_mcu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_en_o
);

  logic [REG_OFFSET_W-1:0] offset;
  logic [GPIO_WIDTH-1:0]   gpio_meta_q;
  logic [GPIO_WIDTH-1:0]   gpio_sync_q;

  assign offset = addr_i[REG_OFFSET_W-1:0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_o      <= '0;
      gpio_en_o   <= '0;
      gpio_meta_q <= '0;
      gpio_sync_q <= '0;
    end else begin
      // two-flop input synchronizer
      gpio_meta_q <= gpio_i;
      gpio_sync_q <= gpio_meta_q;
      if (req_i && we_i && (offset == GPIO_OUT_OFFSET)) begin
        gpio_o <= wdata_i[GPIO_WIDTH-1:0];
      end
      if (req_i && we_i && (offset == GPIO_EN_OFFSET)) begin
        gpio_en_o <= wdata_i[GPIO_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (offset)
        GPIO_OUT_OFFSET: rdata_o <= DATA_WIDTH'(gpio_o);
        GPIO_EN_OFFSET:  rdata_o <= DATA_WIDTH'(gpio_en_o);
        GPIO_IN_OFFSET:  rdata_o <= DATA_WIDTH'(gpio_sync_q);
        default:         rdata_o <= '0;
      endcase
    end
  end

endmodule : peripheral_subsystem

`default_nettype wire

/* rtl/core_v_mini_mcu.sv */
//****************************************
// mini mcu top level
// bus fabric with ram, always-on block and gpio
//****************************************

`default_nettype none

module core_v_mini_mcu
  import obi_pkg::*;
  import core_v_mini_mcu_pkg::*;
(
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,

  input  logic [NUM_MASTERS-1:0]                 ext_master_req_i,
  input  logic [NUM_MASTERS-1:0]                 ext_master_we_i,
  input  logic [NUM_MASTERS-1:0][BE_WIDTH-1:0]   ext_master_be_i,
  input  logic [NUM_MASTERS-1:0][ADDR_WIDTH-1:0] ext_master_addr_i,
  input  logic [NUM_MASTERS-1:0][DATA_WIDTH-1:0] ext_master_wdata_i,
  output logic [NUM_MASTERS-1:0]                 ext_master_gnt_o,
  output logic [NUM_MASTERS-1:0]                 ext_master_rvalid_o,
  output logic [NUM_MASTERS-1:0][DATA_WIDTH-1:0] ext_master_rdata_o,

  input  logic                                   boot_select_i,
  output logic                                   exit_valid_o,
  output logic [DATA_WIDTH-1:0]                  exit_value_o,
  output logic                                   irq_timer_o,

  input  logic [GPIO_WIDTH-1:0]                  gpio_i,
  output logic [GPIO_WIDTH-1:0]                  gpio_o,
  output logic [GPIO_WIDTH-1:0]                  gpio_en_o
);

  // ram banks
  logic [NUM_BANKS-1:0]                 ram_req;
  logic                                 ram_we;
  logic [BE_WIDTH-1:0]                  ram_be;
  logic [ADDR_WIDTH-1:0]                ram_addr;
  logic [DATA_WIDTH-1:0]                ram_wdata;
  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] ram_rdata;

  // always-on peripherals
  logic                                 ao_req;
  logic                                 ao_we;
  logic [ADDR_WIDTH-1:0]                ao_addr;
  logic [DATA_WIDTH-1:0]                ao_wdata;
  logic [DATA_WIDTH-1:0]                ao_rdata;

  // gpio block
  logic                                 periph_req;
  logic                                 periph_we;
  logic [ADDR_WIDTH-1:0]                periph_addr;
  logic [DATA_WIDTH-1:0]                periph_wdata;
  logic [DATA_WIDTH-1:0]                periph_rdata;

  system_bus system_bus_i (
    .clk_i,
    .rst_n_i,
    .req_i         (ext_master_req_i),
    .we_i          (ext_master_we_i),
    .be_i          (ext_master_be_i),
    .addr_i        (ext_master_addr_i),
    .wdata_i       (ext_master_wdata_i),
    .gnt_o         (ext_master_gnt_o),
    .rvalid_o      (ext_master_rvalid_o),
    .rdata_o       (ext_master_rdata_o),
    .ram_req_o     (ram_req),
    .ram_we_o      (ram_we),
    .ram_be_o      (ram_be),
    .ram_addr_o    (ram_addr),
    .ram_wdata_o   (ram_wdata),
    .ram_rdata_i   (ram_rdata),
    .ao_req_o      (ao_req),
    .ao_we_o       (ao_we),
    .ao_addr_o     (ao_addr),
    .ao_wdata_o    (ao_wdata),
    .ao_rdata_i    (ao_rdata),
    .periph_req_o  (periph_req),
    .periph_we_o   (periph_we),
    .periph_addr_o (periph_addr),
    .periph_wdata_o(periph_wdata),
    .periph_rdata_i(periph_rdata)
  );

  memory_subsystem #(
    .NUM_BYTES(MEM_SIZE)
  ) memory_subsystem_i (
    .clk_i,
    .rst_n_i,
    .ram_req_i  (ram_req),
    .ram_we_i   (ram_we),
    .ram_be_i   (ram_be),
    .ram_addr_i (ram_addr),
    .ram_wdata_i(ram_wdata),
    .ram_rdata_o(ram_rdata)
  );

  ao_peripheral_subsystem ao_peripheral_subsystem_i (
    .clk_i,
    .rst_n_i,
    .req_i  (ao_req),
    .we_i   (ao_we),
    .addr_i (ao_addr),
    .wdata_i(ao_wdata),
    .boot_select_i,
    .rdata_o(ao_rdata),
    .exit_valid_o,
    .exit_value_o,
    .irq_timer_o
  );

  peripheral_subsystem peripheral_subsystem_i (
    .clk_i,
    .rst_n_i,
    .req_i  (periph_req),
    .we_i   (periph_we),
    .addr_i (periph_addr),
    .wdata_i(periph_wdata),
    .gpio_i,
    .rdata_o(periph_rdata),
    .gpio_o,
    .gpio_en_o
  );

endmodule : core_v_mini_mcu

`default_nettype wire

/* dv/tb_clock_gen.sv */
//****************************************
// testbench clock and reset
//****************************************

`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD       = 20,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release just after an edge, away from the sampling point
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire

/* dv/tb_core_v_mini_mcu.sv */
//****************************************
// mini mcu testbench
// two random bus masters checked against a model
//****************************************

`default_nettype none

module tb_core_v_mini_mcu
  import obi_pkg::*;
  import core_v_mini_mcu_pkg::*;
();

  localparam int unsigned RANDOM_CYCLES  = 400;
  localparam int unsigned WAIT_LIMIT     = 50;
  localparam int unsigned RAM_TEST_WORDS = 32;

  logic                                   clk;
  logic                                   rst_n;
  logic [NUM_MASTERS-1:0]                 req;
  logic [NUM_MASTERS-1:0]                 we;
  logic [NUM_MASTERS-1:0][BE_WIDTH-1:0]   be;
  logic [NUM_MASTERS-1:0][ADDR_WIDTH-1:0] addr;
  logic [NUM_MASTERS-1:0][DATA_WIDTH-1:0] wdata;
  logic [NUM_MASTERS-1:0]                 gnt;
  logic [NUM_MASTERS-1:0]                 rvalid;
  logic [NUM_MASTERS-1:0][DATA_WIDTH-1:0] rdata;
  logic                                   boot_select;
  logic                                   exit_valid;
  logic [DATA_WIDTH-1:0]                  exit_value;
  logic                                   irq_timer;
  logic [GPIO_WIDTH-1:0]                  gpio_in;
  logic [GPIO_WIDTH-1:0]                  gpio_out;
  logic [GPIO_WIDTH-1:0]                  gpio_en;

  // reference model state
  logic [DATA_WIDTH-1:0]                  ram_img [RAM_TEST_WORDS];
  logic                                   exit_valid_m;
  logic [DATA_WIDTH-1:0]                  exit_value_m;
  logic [DATA_WIDTH-1:0]                  mtimecmp_m;
  logic [GPIO_WIDTH-1:0]                  gpio_out_m;
  logic [GPIO_WIDTH-1:0]                  gpio_en_m;

  logic [NUM_MASTERS-1:0]                 resp_due;
  logic [NUM_MASTERS-1:0]                 req_held;
  logic [NUM_MASTERS-1:0][DATA_WIDTH-1:0] resp_exp;
  logic [31:0]                            rng_state;
  int unsigned                            errors;
  int unsigned                            transfers;

  tb_clock_gen #(
    .PERIOD      (20),
    .RESET_CYCLES(5)
  ) i_clock_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  core_v_mini_mcu i_dut (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .ext_master_req_i   (req),
    .ext_master_we_i    (we),
    .ext_master_be_i    (be),
    .ext_master_addr_i  (addr),
    .ext_master_wdata_i (wdata),
    .ext_master_gnt_o   (gnt),
    .ext_master_rvalid_o(rvalid),
    .ext_master_rdata_o (rdata),
    .boot_select_i      (boot_select),
    .exit_valid_o       (exit_valid),
    .exit_value_o       (exit_value),
    .irq_timer_o        (irq_timer),
    .gpio_i             (gpio_in),
    .gpio_o             (gpio_out),
    .gpio_en_o          (gpio_en)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] ao_reg(input logic [REG_OFFSET_W-1:0] off);
    return AO_PERIPH_START_ADDRESS | 32'(off);
  endfunction

  function automatic logic [31:0] gpio_reg(input logic [REG_OFFSET_W-1:0] off);
    return PERIPH_START_ADDRESS | 32'(off);
  endfunction

  // 16 words in each bank are exercised
  function automatic logic [31:0] ram_word_addr(input logic [4:0] slot);
    return {20'h0, slot[4], 5'b0, slot[3:0], 2'b00};
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
  endfunction

  // applies one transfer and returns the rdata the bus must answer with
  function automatic logic [31:0] apply_model(input logic w, input logic [BE_WIDTH-1:0] b,
                                              input logic [31:0] a, input logic [31:0] d);
    logic [31:0]             rd;
    logic [REG_OFFSET_W-1:0] off;
    int unsigned             slot;
    rd = '0;
    off = a[REG_OFFSET_W-1:0];
    slot = 32'({a[RAM_BANK_BIT], a[5:2]});
    if (a < 32'(MEM_SIZE)) begin
      if (w) begin
        for (int i = 0; i < BE_WIDTH; i++) begin
          if (b[i]) begin
            ram_img[slot][i*8 +: 8] = d[i*8 +: 8];
          end
        end
      end else begin
        rd = ram_img[slot];
      end
    end else if (a[31:12] == AO_PERIPH_START_ADDRESS[31:12]) begin
      if (w) begin
        case (off)
          EXIT_VALID_OFFSET: exit_valid_m = exit_valid_m | d[0];
          EXIT_VALUE_OFFSET: exit_value_m = d;
          MTIMECMP_OFFSET:   mtimecmp_m = d;
          default:           ;
        endcase
      end else begin
        case (off)
          EXIT_VALID_OFFSET:  rd = 32'(exit_valid_m);
          EXIT_VALUE_OFFSET:  rd = exit_value_m;
          BOOT_SELECT_OFFSET: rd = 32'(boot_select);
          MTIMECMP_OFFSET:    rd = mtimecmp_m;
          default:            rd = '0;
        endcase
      end
    end else if (a[31:12] == PERIPH_START_ADDRESS[31:12]) begin
      if (w) begin
        case (off)
          GPIO_OUT_OFFSET: gpio_out_m = d;
          GPIO_EN_OFFSET:  gpio_en_m = d;
          default:         ;
        endcase
      end else begin
        case (off)
          GPIO_OUT_OFFSET: rd = gpio_out_m;
          GPIO_EN_OFFSET:  rd = gpio_en_m;
          GPIO_IN_OFFSET:  rd = gpio_in;
          default:         rd = '0;
        endcase
      end
    end
    return rd;
  endfunction

  task automatic flag_mismatch(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("FAIL @%0t: %s is %h, expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic note_failure(input string msg);
    $display("ERROR @%0t: %s", $time, msg);
    errors++;
  endtask

  // new random transfer for an idle master
  task automatic make_request(input int m);
    logic [31:0] r;
    logic [31:0] a;
    r = rand32();
    a = rand32();
    req[m]   = (r[1:0] != 2'b00);
    we[m]    = r[2];
    be[m]    = r[6:3];
    wdata[m] = rand32();
    if (r[10:7] < 4'd11) begin
      addr[m] = ram_word_addr(a[4:0]);
    end else if (r[10:7] < 4'd14) begin
      case (r[13:11])
        3'd0:    addr[m] = ao_reg(EXIT_VALUE_OFFSET);
        3'd1:    addr[m] = ao_reg(MTIMECMP_OFFSET);
        3'd2:    addr[m] = ao_reg(BOOT_SELECT_OFFSET);
        3'd3:    addr[m] = gpio_reg(GPIO_OUT_OFFSET);
        3'd4:    addr[m] = gpio_reg(GPIO_EN_OFFSET);
        3'd5: begin
          addr[m] = ao_reg(EXIT_VALID_OFFSET);
          we[m] = 1'b0;
        end
        3'd6: begin
          addr[m] = gpio_reg(GPIO_IN_OFFSET);
          we[m] = 1'b0;
        end
        default: addr[m] = ao_reg(12'hffc);
      endcase
    end else if (r[14]) begin
      // just past the ram
      addr[m] = 32'(MEM_SIZE) + {20'h0, a[11:2], 2'b00};
    end else begin
      addr[m] = 32'h1000_0000 | {20'h0, a[11:2], 2'b00};
    end
  endtask

  // runs at the falling edge where all DUT outputs have settled
  task automatic check_cycle();
    logic [NUM_MASTERS-1:0] exp_gnt;
    exp_gnt = '0;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      if (resp_due[m]) begin
        if (!rvalid[m]) begin
          note_failure($sformatf("master %0d got no rvalid one cycle after its grant", m));
        end else if (rdata[m] !== resp_exp[m]) begin
          flag_mismatch($sformatf("master %0d rdata", m), rdata[m], resp_exp[m]);
        end
      end else if (rvalid[m]) begin
        note_failure($sformatf("master %0d got rvalid without a granted transfer", m));
      end
    end
    resp_due = '0;
    // lowest index wins
    for (int m = 0; m < NUM_MASTERS; m++) begin
      if (req[m] && (exp_gnt == '0)) begin
        exp_gnt[m] = 1'b1;
      end
    end
    if (gnt !== exp_gnt) begin
      flag_mismatch("gnt", 32'(gnt), 32'(exp_gnt));
    end
    for (int m = 0; m < NUM_MASTERS; m++) begin
      if (exp_gnt[m]) begin
        resp_exp[m] = apply_model(we[m], be[m], addr[m], wdata[m]);
        resp_due[m] = 1'b1;
        transfers++;
      end
    end
    req_held = req & ~exp_gnt;
  endtask

  // full-word transfer on master 0 while master 1 stays idle
  task automatic single_transfer(input logic w, input logic [31:0] a, input logic [31:0] d,
                                 output logic [31:0] rd);
    int unsigned waited;
    @(posedge clk);
    #2;
    req[0]   = 1'b1;
    we[0]    = w;
    be[0]    = '1;
    addr[0]  = a;
    wdata[0] = d;
    waited = 0;
    @(negedge clk);
    while (!gnt[0] && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!gnt[0]) begin
      note_failure("timed out waiting for gnt on master 0");
    end
    void'(apply_model(w, '1, a, d));
    @(posedge clk);
    #2;
    req[0] = 1'b0;
    @(negedge clk);
    if (!rvalid[0]) begin
      note_failure("master 0 got no rvalid one cycle after its grant");
    end
    rd = rdata[0];
    if (w && (rd != '0)) begin
      flag_mismatch("write response rdata", rd, '0);
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] v;
    int unsigned waited;
    int unsigned n;
    rng_state = 32'h6ca6acbf;
    errors = 0;
    transfers = 0;
    req = '0;
    we = '0;
    be = '0;
    addr = '0;
    wdata = '0;
    resp_due = '0;
    resp_exp = '0;
    req_held = '0;
    exit_valid_m = 1'b0;
    exit_value_m = '0;
    mtimecmp_m = '0;
    gpio_out_m = '0;
    gpio_en_m = '0;
    v = rand32();
    boot_select = v[0];
    gpio_in = rand32();

    waited = 0;
    while ((rst_n !== 1'b1) && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      note_failure("reset was never released");
    end
    if ((gnt !== '0) || (rvalid !== '0) || (exit_valid !== 1'b0) || (irq_timer !== 1'b0) ||
        (gpio_out !== '0) || (gpio_en !== '0)) begin
      note_failure("outputs are not low after reset");
    end

    for (int i = 0; i < RAM_TEST_WORDS; i++) begin
      single_transfer(1'b1, ram_word_addr(5'(i)), fill_word(ram_word_addr(5'(i))), rd);
    end

    // both masters at random over ram, registers and unmapped space
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      @(posedge clk);
      #2;
      for (int m = 0; m < NUM_MASTERS; m++) begin
        if (!req_held[m]) begin
          make_request(m);
        end
      end
      @(negedge clk);
      check_cycle();
    end
    @(posedge clk);
    #2;
    req = '0;
    @(negedge clk);
    check_cycle();

    single_transfer(1'b0, ao_reg(BOOT_SELECT_OFFSET), '0, rd);
    if (rd != 32'(boot_select)) begin
      flag_mismatch("BOOT_SELECT", rd, 32'(boot_select));
    end
    v = rand32();
    single_transfer(1'b1, ao_reg(EXIT_VALUE_OFFSET), v, rd);
    single_transfer(1'b1, ao_reg(EXIT_VALID_OFFSET), 32'h1, rd);
    if (exit_value != v) begin
      flag_mismatch("exit_value_o", exit_value, v);
    end
    if (!exit_valid) begin
      note_failure("exit_valid_o did not rise after the EXIT_VALID write");
    end

    v = rand32();
    n = 4 + 32'(v[3:0]);
    single_transfer(1'b1, ao_reg(MTIME_OFFSET), '0, rd);
    single_transfer(1'b1, ao_reg(MTIMECMP_OFFSET), 32'(n), rd);
    single_transfer(1'b1, ao_reg(TIMER_CTRL_OFFSET), 32'h1, rd);
    waited = 0;
    while (!irq_timer && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!irq_timer) begin
      note_failure("timed out waiting for irq_timer_o");
    end
    single_transfer(1'b0, ao_reg(MTIME_OFFSET), '0, rd);
    if (rd < 32'(n)) begin
      flag_mismatch("mtime below mtimecmp after irq", rd, 32'(n));
    end
    single_transfer(1'b1, ao_reg(TIMER_CTRL_OFFSET), '0, rd);
    waited = 0;
    while (irq_timer && waited < 2) begin
      @(negedge clk);
      waited++;
    end
    if (irq_timer) begin
      note_failure("irq_timer_o still high two cycles after the timer was disabled");
    end

    v = rand32();
    single_transfer(1'b1, gpio_reg(GPIO_OUT_OFFSET), v, rd);
    if (gpio_out != v) begin
      flag_mismatch("gpio_o", gpio_out, v);
    end
    v = rand32();
    single_transfer(1'b1, gpio_reg(GPIO_EN_OFFSET), v, rd);
    if (gpio_en != v) begin
      flag_mismatch("gpio_en_o", gpio_en, v);
    end
    @(posedge clk);
    #2;
    gpio_in = rand32();
    // hold the pins past the two synchronizer flops
    repeat (3) @(posedge clk);
    single_transfer(1'b0, gpio_reg(GPIO_IN_OFFSET), '0, rd);
    if (rd != gpio_in) begin
      flag_mismatch("GPIO_IN", rd, gpio_in);
    end

    // a zero write must leave exit_valid_o set
    single_transfer(1'b1, ao_reg(EXIT_VALID_OFFSET), 32'h0, rd);
    if (!exit_valid) begin
      note_failure("exit_valid_o fell before the end of the run");
    end
    $display("run complete: %0d random transfers, %0d errors", transfers, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : tb_core_v_mini_mcu

`default_nettype wire

/* core_v_mini_mcu.f */
rtl/obi_pkg.sv
rtl/core_v_mini_mcu_pkg.sv
rtl/system_bus.sv
rtl/memory_subsystem.sv
rtl/ao_peripheral_subsystem.sv
rtl/peripheral_subsystem.sv
rtl/core_v_mini_mcu.sv
dv/tb_clock_gen.sv
dv/tb_core_v_mini_mcu.sv

/* run_sim.sh */
#!/bin/sh
# builds the mini mcu testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_core_v_mini_mcu \
  -f core_v_mini_mcu.f \
  --Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

OUTPUT=$("$BUILD_DIR/sim")
STATUS=$?
printf '%s\n' "$OUTPUT"
if [ $STATUS -ne 0 ]; then
  echo "simulation exited with status $STATUS"
  exit 1
fi

if printf '%s\n' "$OUTPUT" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
